// File: testbench/dcache_vectors.txt
# Columns are op (R read, W write, I invalidate), address or set, data, byte select,
# expected read data, and the expected dump block base (ffffffff when no dump happens)
R 00000000 00000000 0 5a5a0000 ffffffff
R 00000024 00000000 0 5a5a0024 ffffffff
R 0000004c 00000000 0 5a5a004c ffffffff
W 00000004 11223344 3 00000000 ffffffff
R 00000004 00000000 0 5a5a3344 ffffffff
W 00000028 aabbccdd c 00000000 ffffffff
R 00000028 00000000 0 aabb0028 ffffffff
W 00000058 deadbeef f 00000000 ffffffff
R 00000058 00000000 0 deadbeef ffffffff
W 00000010 01010101 f 00000000 ffffffff
W 00000114 02020202 f 00000000 ffffffff
R 00000218 00000000 0 5a5a0218 00000010
R 00000010 00000000 0 01010101 00000110
R 00000114 00000000 0 02020202 ffffffff
R 00000030 00000000 0 5a5a0030 ffffffff
W 00000134 cafef00d f 00000000 ffffffff
R 00000030 00000000 0 5a5a0030 ffffffff
R 00000230 00000000 0 5a5a0230 00000130
R 00000134 00000000 0 cafef00d ffffffff
R 00000060 00000000 0 5a5a0060 ffffffff
W 00000064 87654321 f 00000000 ffffffff
R 00000064 00000000 0 87654321 ffffffff
I 00000006 00000000 0 00000000 ffffffff
R 00000064 00000000 0 5a5a0064 ffffffff
R 000003f8 00000000 0 5a5a03f8 ffffffff
R 00000ffc 00000000 0 5a5a0ffc ffffffff
W 000003f8 00770000 4 00000000 ffffffff
R 000003f8 00000000 0 5a7703f8 ffffffff

// File: tb.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_tag_if.sv
hdl/dcache_dpram.sv
hdl/dcache_tag_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_asserts.sv
testbench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/dcache_tag_if.sv
      - hdl/dcache_dpram.sv
      - hdl/dcache_tag_array.sv
      - hdl/dcache_ctrl.sv
      - hdl/dcache_top.sv
  - target: simulation
    files:
      - testbench/dcache_asserts.sv
      - testbench/tb_dcache.sv

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps

`include "dcache_config.svh"

module tb_dcache import dcache_pkg::*; ();

   localparam int    CLK_PERIOD   = 8;
   localparam int    RESET_CYCLES = 16;
   localparam int    LINE_CYCLES  = 200;
   // Dump column value of an operation that must not dump
   localparam word_t NO_DUMP      = 32'hffff_ffff;

   logic   clk;
   logic   rst;
   logic   req_i;
   logic   we_i;
   word_t  adr_i;
   word_t  dat_i;
   bsel_t  bsel_i;
   logic   ack_o;
   word_t  dat_o;
   logic   inv_i;
   index_t inv_index_i;
   logic   dump_valid_o;
   word_t  dump_adr_o;
   word_t  dump_dat_o;
   logic   refill_req_o;
   word_t  refill_adr_o;
   logic   mem_valid_i;
   word_t  mem_dat_i;

   // One entry per vector line
   byte   vec_op   [$];
   word_t vec_adr  [$];
   word_t vec_dat  [$];
   bsel_t vec_bsel [$];
   word_t vec_rdat [$];
   word_t vec_dump [$];
   int    vec_count;

   // Memory behind the cache, filled with a pattern of the byte address
   word_t mem [0:`DC_MEM_WORDS-1];

   // Dump bookkeeping for the operation in progress
   int    dump_total;
   int    dump_start;
   word_t dump_base;
   logic  dump_expected;

   dcache_top dcache_top_inst (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req_i),
      .we_i         (we_i),
      .adr_i        (adr_i),
      .dat_i        (dat_i),
      .bsel_i       (bsel_i),
      .ack_o        (ack_o),
      .dat_o        (dat_o),
      .inv_i        (inv_i),
      .inv_index_i  (inv_index_i),
      .dump_valid_o (dump_valid_o),
      .dump_adr_o   (dump_adr_o),
      .dump_dat_o   (dump_dat_o),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .mem_valid_i  (mem_valid_i),
      .mem_dat_i    (mem_dat_i)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Word slot of a byte address in the memory model
   function automatic int mem_index(input word_t adr);
      return int'((adr >> 2) % `DC_MEM_WORDS);
   endfunction

   // Sum of the failures seen by the bound assertion module
   function automatic int protocol_errors();
      return dcache_top_inst.dcache_asserts_inst.ack_errs +
             dcache_top_inst.dcache_asserts_inst.dump_errs +
             dcache_top_inst.dcache_asserts_inst.reset_errs;
   endfunction

   task automatic stop_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("FAIL time %0t %s expected %h got %h", $time, name, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_adr(input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("FAIL time %0t dump_adr_o expected %h got %h", $time, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_count(input int expected, input int actual);
      if (actual != expected) begin
         $display("FAIL time %0t dump_valid_o pulses expected %0d got %0d",
                  $time, expected, actual);
         stop_run();
      end
   endtask

   // One read or write, held until the cache acknowledges it
   task automatic run_access(input logic write, input word_t adr, input word_t dat,
                             input bsel_t bsel, input word_t rdat, input word_t dbase);
      dump_start    = dump_total;
      dump_base     = dbase;
      dump_expected = (dbase != NO_DUMP);
      @(posedge clk);
      #1;
      req_i  = 1'b1;
      we_i   = write;
      adr_i  = adr;
      dat_i  = dat;
      bsel_i = bsel;
      @(negedge clk);
      while (ack_o !== 1'b1) begin
         @(negedge clk);
      end
      if (!write) begin
         check_word("dat_o", rdat, dat_o);
      end
      @(posedge clk);
      #1;
      req_i = 1'b0;
      we_i  = 1'b0;
      check_count(dump_expected ? `DC_WORDS : 0, dump_total - dump_start);
   endtask

   // Strobe for one cycle, then allow the single INVAL cycle to pass
   task automatic run_invalidate(input index_t set);
      @(posedge clk);
      #1;
      inv_i       = 1'b1;
      inv_index_i = set;
      @(posedge clk);
      #1;
      inv_i = 1'b0;
      @(posedge clk);
      #1;
   endtask

   initial begin : sequencer
      string line;
      int    fd;
      int    fields;
      byte   op;
      word_t adr;
      word_t dat;
      bsel_t bsel;
      word_t rdat;
      word_t dbase;
      rst           = 1'b1;
      req_i         = 1'b0;
      we_i          = 1'b0;
      adr_i         = '0;
      dat_i         = '0;
      bsel_i        = '0;
      inv_i         = 1'b0;
      inv_index_i   = '0;
      dump_start    = 0;
      dump_base     = NO_DUMP;
      dump_expected = 1'b0;
      vec_count     = 0;
      fd = $fopen("testbench/dcache_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/dcache_vectors.txt for reading");
         stop_run();
      end
      // Lines that do not start with R, W or I and six fields are comments
      while (!$feof(fd)) begin
         line   = "";
         fields = $fgets(line, fd);
         if (fields > 0) begin
            fields = $sscanf(line, "%c %h %h %h %h %h", op, adr, dat, bsel, rdat, dbase);
            if (fields == 6 && (op == "R" || op == "W" || op == "I")) begin
               vec_op.push_back(op);
               vec_adr.push_back(adr);
               vec_dat.push_back(dat);
               vec_bsel.push_back(bsel);
               vec_rdat.push_back(rdat);
               vec_dump.push_back(dbase);
            end
         end
      end
      $fclose(fd);
      vec_count = vec_op.size();
      if (vec_count == 0) begin
         $display("The vector file holds no operations");
         stop_run();
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      // Give the tag array time to finish its clearing sweep
      repeat ((1 << `DC_SET_W) + 2) @(posedge clk);
      for (int i = 0; i < vec_count; i++) begin
         case (vec_op[i])
            "R": run_access(1'b0, vec_adr[i], vec_dat[i], vec_bsel[i], vec_rdat[i],
                            vec_dump[i]);
            "W": run_access(1'b1, vec_adr[i], vec_dat[i], vec_bsel[i], vec_rdat[i],
                            vec_dump[i]);
            default: run_invalidate(index_t'(vec_adr[i]));
         endcase
      end
      if (protocol_errors() != 0) begin
         $display("A protocol assertion on dcache_top failed during the run");
         stop_run();
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

   // A failed protocol assertion ends the run at the next falling edge
   initial begin : protocol_watch
      forever begin
         @(negedge clk);
         if (protocol_errors() != 0) begin
            $display("A protocol assertion on dcache_top failed");
            stop_run();
         end
      end
   end

   // Memory model, which takes every dump word and checks where it lands
   initial begin : memory_model
      for (int i = 0; i < `DC_MEM_WORDS; i++) begin
         mem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
      end
      dump_total = 0;
      forever begin
         @(negedge clk);
         if (!rst && dump_valid_o === 1'b1) begin
            if (dump_expected) begin
               check_adr(dump_base + word_t'((dump_total - dump_start) * 4), dump_adr_o);
            end
            mem[mem_index(dump_adr_o)] = dump_dat_o;
            dump_total++;
         end
      end
   end

   // Refill side of memory, with random gaps of up to two cycles between words
   initial begin : refill_server
      int seed_ret;
      int served;
      int gap;
      seed_ret    = $urandom(32'h8115_ff9d);
      mem_valid_i = 1'b0;
      mem_dat_i   = '0;
      served      = 0;
      gap         = 0;
      forever begin
         @(posedge clk);
         #1;
         if (rst || refill_req_o !== 1'b1) begin
            mem_valid_i = 1'b0;
            served      = 0;
            gap         = $urandom_range(2, 0);
         end else if (gap > 0 || served >= `DC_WORDS) begin
            mem_valid_i = 1'b0;
            if (gap > 0) begin
               gap--;
            end
         end else begin
            mem_valid_i = 1'b1;
            mem_dat_i   = mem[mem_index(refill_adr_o + word_t'(served * 4))];
            served++;
            gap = $urandom_range(2, 0);
         end
      end
   end

   // Ends a run that stalls, with a budget per vector line plus reset time
   initial begin : watchdog
      #1;
      repeat (LINE_CYCLES * (vec_count + 1)) @(posedge clk);
      $display("Watchdog timeout, the vector list did not finish in time");
      stop_run();
   end

endmodule

// File: testbench/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts (
   input logic clk,
   input logic rst,
   input logic req_i,
   input logic ack_i,
   input logic dump_valid_i,
   input logic refill_req_i
);

   // Failure counts, summed by the testbench during and at the end of the run
   int ack_errs   = 0;
   int dump_errs  = 0;
   int reset_errs = 0;

   // An acknowledge only ever answers a request that is still held
   ack_with_req: assert property (
      @(posedge clk) disable iff (rst) $rose(ack_i) |-> req_i
   ) else begin
      $error("ack_o rose while req_i was low");
      ack_errs++;
   end

   // A dump is four words on consecutive cycles
   // The refill takes over in the very next cycle, with the dump already finished
   dump_then_refill: assert property (
      @(posedge clk) disable iff (rst)
         $rose(dump_valid_i) |-> ##1 dump_valid_i ##1 dump_valid_i ##1 dump_valid_i
                                 ##1 (refill_req_i && !dump_valid_i)
   ) else begin
      $error("dump burst was not four words directly followed by the refill");
      dump_errs++;
   end

   // From the second reset cycle on, the outputs are cleared
   quiet_in_reset: assert property (
      @(posedge clk) (rst && $past(rst)) |-> (!ack_i && !dump_valid_i && !refill_req_i)
   ) else begin
      $error("ack_o, dump_valid_o or refill_req_o was high during reset");
      reset_errs++;
   end

endmodule

bind dcache_top dcache_asserts dcache_asserts_inst (
   .clk          (clk),
   .rst          (rst),
   .req_i        (req_i),
   .ack_i        (ack_o),
   .dump_valid_i (dump_valid_o),
   .refill_req_i (refill_req_o)
);

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_top import dcache_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   // Processor request
   input  logic   req_i,
   input  logic   we_i,
   input  word_t  adr_i,
   input  word_t  dat_i,
   input  bsel_t  bsel_i,
   output logic   ack_o,
   output word_t  dat_o,
   // Set invalidate
   input  logic   inv_i,
   input  index_t inv_index_i,
   // Victim dump
   output logic   dump_valid_o,
   output word_t  dump_adr_o,
   output word_t  dump_dat_o,
   // Refill
   output logic   refill_req_o,
   output word_t  refill_adr_o,
   input  logic   mem_valid_i,
   input  word_t  mem_dat_i
);

   // Word address inside one way, set index and word offset
   localparam int WAY_AW = `DC_SET_W + `DC_BLOCK_W - 2;

   logic [WAY_AW-1:0] way_raddr;
   logic [WAY_AW-1:0] way_waddr;
   way_sel_t          way_we;
   word_t             way_wdat;
   word_t             way0_rdat;
   word_t             way1_rdat;

   dcache_tag_if tag_if ();

   dcache_ctrl ctrl (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req_i),
      .we_i         (we_i),
      .adr_i        (adr_i),
      .dat_i        (dat_i),
      .bsel_i       (bsel_i),
      .ack_o        (ack_o),
      .dat_o        (dat_o),
      .inv_i        (inv_i),
      .inv_index_i  (inv_index_i),
      .dump_valid_o (dump_valid_o),
      .dump_adr_o   (dump_adr_o),
      .dump_dat_o   (dump_dat_o),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .mem_valid_i  (mem_valid_i),
      .mem_dat_i    (mem_dat_i),
      .way_raddr_o  (way_raddr),
      .way_waddr_o  (way_waddr),
      .way_we_o     (way_we),
      .way_wdat_o   (way_wdat),
      .way0_rdat_i  (way0_rdat),
      .way1_rdat_i  (way1_rdat),
      .tag          (tag_if.ctrl)
   );

   dcache_tag_array tag_array (
      .clk (clk),
      .rst (rst),
      .tag (tag_if.array)
   );

   // Both ways share the address and data buses, only the write enables differ
   dcache_dpram #(.DEPTH_W(WAY_AW), .payload_t(word_t)) way0_ram (
      .clk     (clk),
      .raddr_i (way_raddr),
      .waddr_i (way_waddr),
      .we_i    (way_we[0]),
      .wdat_i  (way_wdat),
      .rdat_o  (way0_rdat)
   );

   dcache_dpram #(.DEPTH_W(WAY_AW), .payload_t(word_t)) way1_ram (
      .clk     (clk),
      .raddr_i (way_raddr),
      .waddr_i (way_waddr),
      .we_i    (way_we[1]),
      .wdat_i  (way_wdat),
      .rdat_o  (way1_rdat)
   );

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*; (
   input  logic                           clk,
   input  logic                           rst,
   // Processor request
   input  logic                           req_i,
   input  logic                           we_i,
   input  word_t                          adr_i,
   input  word_t                          dat_i,
   input  bsel_t                          bsel_i,
   output logic                           ack_o,
   output word_t                          dat_o,
   // Set invalidate
   input  logic                           inv_i,
   input  index_t                         inv_index_i,
   // Victim dump to memory
   output logic                           dump_valid_o,
   output word_t                          dump_adr_o,
   output word_t                          dump_dat_o,
   // Block refill from memory
   output logic                           refill_req_o,
   output word_t                          refill_adr_o,
   input  logic                           mem_valid_i,
   input  word_t                          mem_dat_i,
   // Way data RAMs
   output logic [`DC_SET_W+`DC_BLOCK_W-3:0] way_raddr_o,
   output logic [`DC_SET_W+`DC_BLOCK_W-3:0] way_waddr_o,
   output way_sel_t                       way_we_o,
   output word_t                          way_wdat_o,
   input  word_t                          way0_rdat_i,
   input  word_t                          way1_rdat_i,
   dcache_tag_if.ctrl                     tag
);

   state_t state;

   // Fields of the request address, held steady by the requester
   tag_t   req_tag;
   index_t req_index;
   woff_t  req_woff;

   // Word counter shared by the dump and the refill bursts
   woff_t cnt;
   logic  last_word;

   // Victim chosen at the miss
   way_sel_t victim_q;
   tag_t     victim_tag_q;
   logic     victim_idx;

   index_t inv_index_q;

   logic     hit;
   logic     hit_idx;
   word_t    hit_word;
   word_t    victim_word;
   word_t    merged;
   logic     tag_we;
   tag_set_t new_set;

   assign req_tag   = adr_i[`DC_ADDR_W-1:`DC_SET_W+`DC_BLOCK_W];
   assign req_index = adr_i[`DC_SET_W+`DC_BLOCK_W-1:`DC_BLOCK_W];
   assign req_woff  = adr_i[`DC_BLOCK_W-1:2];

   assign hit         = |tag.hit_way;
   assign hit_idx     = tag.hit_way[1];
   assign victim_idx  = victim_q[1];
   assign hit_word    = hit_idx ? way1_rdat_i : way0_rdat_i;
   assign victim_word = victim_idx ? way1_rdat_i : way0_rdat_i;
   assign last_word   = (cnt == woff_t'(`DC_WORDS - 1));

   // Store data replaces only the enabled bytes of the cached word
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = bsel_i[b] ? dat_i[8*b +: 8] : hit_word[8*b +: 8];
      end
   end

   // The set of the request is looked up in every state
   // The RAM output then belongs to the current request one cycle later
   assign tag.rd_index = req_index;
   assign tag.cmp_tag  = req_tag;
   assign tag.wr_index = (state == INVAL) ? inv_index_q : req_index;
   assign tag.wr_en    = tag_we;
   assign tag.wr_set   = new_set;

   // Tag memory updates, always based on the set that was just read
   always_comb begin
      tag_we  = 1'b0;
      new_set = tag.cur_set;
      case (state)
         LOOKUP: begin
            // A read hit only moves the LRU away from the hit way
            if (hit && !we_i) begin
               tag_we      = 1'b1;
               new_set.lru = tag.hit_way[0];
            end
         end
         WRITE: begin
            tag_we                     = 1'b1;
            new_set.way[hit_idx].dirty = 1'b1;
            new_set.lru                = tag.hit_way[0];
         end
         REFILL: begin
            // The new tag goes in with the last word, clean and valid
            if (mem_valid_i && last_word) begin
               tag_we                        = 1'b1;
               new_set.way[victim_idx].dirty = 1'b0;
               new_set.way[victim_idx].valid = 1'b1;
               new_set.way[victim_idx].tag   = req_tag;
               new_set.lru                   = victim_q[0];
            end
         end
         INVAL: begin
            // Both ways and the LRU are cleared, dirty data is lost
            tag_we  = 1'b1;
            new_set = '0;
         end
         default: begin
         end
      endcase
   end

   // On a miss word 0 is read ahead, so the dump emits one word per cycle
   always_comb begin
      if (state == DUMP) begin
         way_raddr_o = {req_index, woff_t'(cnt + 1'b1)};
      end else if ((state == LOOKUP) && !hit) begin
         way_raddr_o = {req_index, woff_t'(0)};
      end else begin
         way_raddr_o = {req_index, req_woff};
      end
   end

   assign way_waddr_o = (state == REFILL) ? {req_index, cnt} : {req_index, req_woff};
   assign way_wdat_o  = (state == REFILL) ? mem_dat_i : merged;
   assign way_we_o    = (state == WRITE) ? tag.hit_way :
                        ((state == REFILL) && mem_valid_i) ? victim_q : '0;

   assign dump_valid_o = (state == DUMP);
   assign dump_adr_o   = {victim_tag_q, req_index, cnt, 2'b00};
   assign dump_dat_o   = victim_word;

   assign refill_req_o = (state == REFILL);
   assign refill_adr_o = {req_tag, req_index, {`DC_BLOCK_W{1'b0}}};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         ack_o <= 1'b0;
         cnt   <= '0;
      end else begin
         ack_o <= 1'b0;
         case (state)
            IDLE: begin
               // While ack_o is high the old request is still on the inputs
               if (inv_i && !req_i) begin
                  state <= INVAL;
               end else if (req_i && !ack_o) begin
                  state <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (hit) begin
                  ack_o <= 1'b1;
                  state <= we_i ? WRITE : IDLE;
               end else begin
                  cnt   <= '0;
                  state <= tag.victim_dirty ? DUMP : REFILL;
               end
            end
            WRITE: state <= IDLE;
            DUMP: begin
               cnt <= cnt + 1'b1;
               if (last_word) begin
                  state <= REFILL;
               end
            end
            REFILL: begin
               // Memory may leave gaps, so only valid words advance
               if (mem_valid_i) begin
                  cnt <= cnt + 1'b1;
                  if (last_word) begin
                     state <= LOOKUP;
                  end
               end
            end
            INVAL: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == LOOKUP) && !hit) begin
         victim_q     <= tag.lru_way;
         victim_tag_q <= tag.victim_tag;
      end
      if ((state == LOOKUP) && hit) begin
         dat_o <= hit_word;
      end
      if (state == IDLE) begin
         inv_index_q <= inv_index_i;
      end
   end

endmodule

// File: hdl/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array import dcache_pkg::*; (
   input logic         clk,
   input logic         rst,
   dcache_tag_if.array tag
);

   // Clear sweep over all sets, started by reset
   logic   clearing;
   logic   ready;
   index_t sweep_idx;

   // Tag RAM ports
   logic     ram_we;
   index_t   ram_waddr;
   tag_set_t ram_wdat;
   tag_set_t ram_rdat;

   tag_entry_t victim;
   way_sel_t   match;

   // The sweep starts with reset and runs until the last set has been written
   // Holding reset longer than one sweep only repeats it
   always_ff @(posedge clk) begin
      if (rst) begin
         clearing <= 1'b1;
      end else if (sweep_idx == '1) begin
         clearing <= 1'b0;
      end
   end

   // The sweep index waits at set 0 outside a sweep
   always_ff @(posedge clk) begin
      if (clearing) begin
         sweep_idx <= sweep_idx + 1'b1;
      end else begin
         sweep_idx <= '0;
      end
   end

   assign ready = ~clearing;

   // Sweep writes take over the write port
   assign ram_we    = clearing | tag.wr_en;
   assign ram_waddr = clearing ? sweep_idx : tag.wr_index;
   assign ram_wdat  = clearing ? '0 : tag.wr_set;

   dcache_dpram #(
      .DEPTH_W   ($bits(index_t)),
      .payload_t (tag_set_t)
   ) tag_ram (
      .clk     (clk),
      .raddr_i (tag.rd_index),
      .waddr_i (ram_waddr),
      .we_i    (ram_we),
      .wdat_i  (ram_wdat),
      .rdat_o  (ram_rdat)
   );

   // A way hits when it holds a valid copy of the requested tag
   for (genvar w = 0; w < 2; w++) begin : g_cmp
      assign match[w] = ram_rdat.way[w].valid && (ram_rdat.way[w].tag == tag.cmp_tag);
   end

   // Nothing hits and nothing needs a dump until the sweep is over
   assign tag.hit_way = match & {2{ready}};

   // The lru bit names the replacement way directly
   assign victim           = ram_rdat.way[ram_rdat.lru];
   assign tag.lru_way      = ram_rdat.lru ? 2'b10 : 2'b01;
   assign tag.victim_tag   = victim.tag;
   // An invalid way never needs a dump even with its dirty bit set
   assign tag.victim_dirty = ready & victim.valid & victim.dirty;

   assign tag.cur_set = ram_rdat;

endmodule

// File: hdl/dcache_dpram.sv
`timescale 1ns/1ps

module dcache_dpram #(
   parameter int  DEPTH_W   = 4,
   parameter type payload_t = logic [31:0]
) (
   input  logic               clk,
   input  logic [DEPTH_W-1:0] raddr_i,
   input  logic [DEPTH_W-1:0] waddr_i,
   input  logic               we_i,
   input  payload_t           wdat_i,
   output payload_t           rdat_o
);

   payload_t mem [0:(1<<DEPTH_W)-1];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdat_i;
      end
      // A read of the location being written sees the new value
      if (we_i && (waddr_i == raddr_i)) begin
         rdat_o <= wdat_i;
      end else begin
         rdat_o <= mem[raddr_i];
      end
   end

endmodule

// File: hdl/dcache_tag_if.sv
`timescale 1ns/1ps

interface dcache_tag_if import dcache_pkg::*; ();

   // Lookup and update requests from the controller
   index_t   rd_index;
   tag_t     cmp_tag;
   logic     wr_en;
   index_t   wr_index;
   tag_set_t wr_set;

   // Lookup results, valid one cycle after rd_index
   way_sel_t hit_way;
   way_sel_t lru_way;
   logic     victim_dirty;
   tag_t     victim_tag;
   tag_set_t cur_set;

   modport ctrl (
      output rd_index, cmp_tag, wr_en, wr_index, wr_set,
      input  hit_way, lru_way, victim_dirty, victim_tag, cur_set
   );

   modport array (
      input  rd_index, cmp_tag, wr_en, wr_index, wr_set,
      output hit_way, lru_way, victim_dirty, victim_tag, cur_set
   );

endinterface

// File: hdl/dcache_pkg.sv
package dcache_pkg;

   `include "dcache_config.svh"

   // One processor data word and its byte enables
   typedef logic [31:0] word_t;
   typedef logic [3:0]  bsel_t;

   // Address fields, from the top: tag, set index, word offset, byte offset
   typedef logic [`DC_ADDR_W-`DC_SET_W-`DC_BLOCK_W-1:0] tag_t;
   typedef logic [`DC_SET_W-1:0]                        index_t;
   typedef logic [`DC_BLOCK_W-3:0]                      woff_t;

   // One-hot selection of way 0 or way 1
   typedef logic [1:0] way_sel_t;

   // Tag memory entry of a single way
   typedef struct packed {
      logic dirty;
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // Whole tag memory word of one set
   // The lru bit holds the number of the way that gets replaced next
   typedef struct packed {
      logic             lru;
      tag_entry_t [1:0] way;
   } tag_set_t;

   // Cache controller states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITE,
      DUMP,
      REFILL,
      INVAL
   } state_t;

endpackage

// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Byte address width seen by the processor and by memory
`define DC_ADDR_W 32

// Byte offset bits inside one cache block
// A block is 16 bytes, which is four 32-bit words
`define DC_BLOCK_W 4

// Set index bits
// Only 16 sets, so that short test sequences already collide in one set
`define DC_SET_W 4

// Words per block, which is also the length of a dump or a refill burst
`define DC_WORDS 4

// Size of the memory model in words
// It must cover every address that the vector file touches
`define DC_MEM_WORDS 4096

`endif
